// ==== hw/float_pkg.sv ====
// Float arithmetic unit shared definitions
// binary32 field layout, the operand word type, the opcode and the
// request word that carries an opcode with its two operands
`default_nettype none

package float_pkg;

    // single-precision word and field widths
    localparam int FLOAT_WIDTH = 32;
    localparam int EXP_WIDTH = 8;
    // stored mantissa, hidden one not included
    localparam int MANT_WIDTH = FLOAT_WIDTH - EXP_WIDTH - 1;
    localparam int EXP_BIAS = 127;

    // ieee-754 bit order, sign on top
    typedef struct packed {
        logic                  sign;
        logic [EXP_WIDTH-1:0]  exp;
        logic [MANT_WIDTH-1:0] mant;
    } float_t;

    // operation selector
    typedef enum logic {
        OP_MUL = 1'b0,
        OP_ADD = 1'b1
    } fp_opcode_e;

    // one request on the input port
    // result is a op b
    typedef struct packed {
        fp_opcode_e op;
        float_t     a;
        float_t     b;
    } fp_req_t;

endpackage

`default_nettype wire

// ==== hw/float_mul.sv ====
// Multi-cycle single-precision multiplier
// req/ack handshake, one operation at a time
// denormal operands flush to +0, the product mantissa is truncated
// no handling of infinity, NaN or exponent range
`timescale 1ns/1ns
`default_nettype none

module float_mul (
    input  logic              clk,
    input  logic              rst,
    input  logic              req,
    input  float_pkg::float_t a,
    input  float_pkg::float_t b,
    output logic              ack,
    output float_pkg::float_t out
);

    // significand with the hidden one restored
    localparam int SIG_W = float_pkg::MANT_WIDTH + 1;
    localparam int PROD_W = 2 * SIG_W;
    // two spare bits so the biased sum does not wrap in the middle
    localparam int EXT_EXP_W = float_pkg::EXP_WIDTH + 2;

    typedef enum logic [1:0] {
        S_IDLE,
        S_PRODUCT,
        S_NORM,
        S_PACK
    } state_e;

    state_e state;

    logic                            zero_op;
    logic                            sign_q;
    logic [EXT_EXP_W-1:0]            exp_q;
    logic [SIG_W-1:0]                sig_a_q;
    logic [SIG_W-1:0]                sig_b_q;
    logic [PROD_W-1:0]               prod_q;
    logic [float_pkg::MANT_WIDTH-1:0] mant_q;

    // zero exponent field means zero, denormals included
    assign zero_op = (a.exp == '0) || (b.exp == '0);

    // sequencing and the ack pulse
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state <= S_IDLE;
            ack <= 1'b0;
        end else begin
            ack <= 1'b0;
            case (state)
                S_IDLE: begin
                    if (req) begin
                        // zero short-cuts straight to the output stage
                        if (zero_op) begin
                            state <= S_PACK;
                        end else begin
                            state <= S_PRODUCT;
                        end
                    end
                end
                S_PRODUCT: begin
                    state <= S_NORM;
                end
                S_NORM: begin
                    state <= S_PACK;
                end
                S_PACK: begin
                    ack <= 1'b1;
                    state <= S_IDLE;
                end
                default: begin
                    state <= S_IDLE;
                end
            endcase
        end
    end

    // datapath, one stage per state
    always_ff @(posedge clk) begin
        case (state)
            S_IDLE: begin
                if (req) begin
                    if (zero_op) begin
                        // always +0, sign dropped
                        sign_q <= 1'b0;
                        exp_q <= '0;
                        mant_q <= '0;
                    end else begin
                        sign_q <= a.sign ^ b.sign;
                        // biased sum, bias removed once
                        exp_q <= EXT_EXP_W'(a.exp) + EXT_EXP_W'(b.exp)
                            - EXT_EXP_W'(float_pkg::EXP_BIAS);
                        sig_a_q <= {1'b1, a.mant};
                        sig_b_q <= {1'b1, b.mant};
                    end
                end
            end
            S_PRODUCT: begin
                // 24x24 full product, 1.0 <= p < 4.0 with point at bit 46
                prod_q <= PROD_W'(sig_a_q) * PROD_W'(sig_b_q);
            end
            S_NORM: begin
                if (prod_q[PROD_W-1]) begin
                    // product in [2,4), shift by 24 and bump the exponent
                    mant_q <= prod_q[PROD_W-2 -: float_pkg::MANT_WIDTH];
                    exp_q <= exp_q + EXT_EXP_W'(1);
                end else begin
                    // already in [1,2), shift by 23
                    mant_q <= prod_q[PROD_W-3 -: float_pkg::MANT_WIDTH];
                end
            end
            S_PACK: begin
                out.sign <= sign_q;
                out.exp <= exp_q[float_pkg::EXP_WIDTH-1:0];
                out.mant <= mant_q;
            end
            default: begin
            end
        endcase
    end

    // controller must wait for the ack before the next req
    req_only_in_idle: assert property (@(posedge clk) disable iff (rst)
        req |-> state == S_IDLE);

    // single-cycle ack pulse
    ack_one_cycle: assert property (@(posedge clk) disable iff (rst)
        ack |=> !ack);

endmodule

`default_nettype wire

// ==== hw/float_add.sv ====
// Multi-cycle single-precision adder
// req/ack handshake, one operation at a time
// align, add or subtract, normalise, pack
// zero-exponent operands count as zero, alignment and result truncate
`timescale 1ns/1ns
`default_nettype none

module float_add (
    input  logic              clk,
    input  logic              rst,
    input  logic              req,
    input  float_pkg::float_t a,
    input  float_pkg::float_t b,
    output logic              ack,
    output float_pkg::float_t out
);

    localparam int EXP_W = float_pkg::EXP_WIDTH;
    // hidden one plus stored mantissa
    localparam int SIG_W = float_pkg::MANT_WIDTH + 1;
    // one carry bit on top
    localparam int SUM_W = SIG_W + 1;
    localparam int SHIFT_W = $clog2(SIG_W);

    typedef enum logic [2:0] {
        S_IDLE,
        S_ALIGN,
        S_SUM,
        S_NORM,
        S_PACK
    } state_e;

    state_e state;

    logic              zero_op;
    float_pkg::float_t a_q;
    float_pkg::float_t b_q;
    float_pkg::float_t base;
    float_pkg::float_t other;
    logic [EXP_W-1:0]  exp_diff;
    logic [SIG_W-1:0]  other_sig;
    logic              sign_q;
    logic [EXP_W-1:0]  exp_q;
    logic              sub_q;
    logic [SIG_W-1:0]  big_q;
    logic [SIG_W-1:0]  small_q;
    logic [SUM_W-1:0]  sum_q;
    logic [SHIFT_W-1:0] norm_shift;
    logic [SIG_W-1:0]  norm_sig;
    float_pkg::float_t res_q;

    assign zero_op = (a.exp == '0) || (b.exp == '0);

    // larger magnitude becomes the base, the other one is aligned to it
    always_comb begin
        if ({a_q.exp, a_q.mant} >= {b_q.exp, b_q.mant}) begin
            base = a_q;
            other = b_q;
        end else begin
            base = b_q;
            other = a_q;
        end
        exp_diff = base.exp - other.exp;
        // 25 or more places leaves nothing of the smaller operand
        if (exp_diff >= EXP_W'(SIG_W + 1)) begin
            other_sig = '0;
        end else begin
            other_sig = {1'b1, other.mant} >> exp_diff;
        end
    end

    // leading-one search over the sum, no carry case only
    always_comb begin
        norm_shift = '0;
        for (int i = 0; i < SIG_W; i++) begin
            if (sum_q[i]) begin
                norm_shift = SHIFT_W'(SIG_W - 1 - i);
            end
        end
        norm_sig = sum_q[SIG_W-1:0] << norm_shift;
    end

    // sequencing and the ack pulse
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state <= S_IDLE;
            ack <= 1'b0;
        end else begin
            ack <= 1'b0;
            case (state)
                S_IDLE: begin
                    if (req) begin
                        if (zero_op) begin
                            state <= S_PACK;
                        end else begin
                            state <= S_ALIGN;
                        end
                    end
                end
                S_ALIGN: state <= S_SUM;
                S_SUM: state <= S_NORM;
                S_NORM: state <= S_PACK;
                S_PACK: begin
                    ack <= 1'b1;
                    state <= S_IDLE;
                end
                default: state <= S_IDLE;
            endcase
        end
    end

    // datapath, one stage per state
    always_ff @(posedge clk) begin
        case (state)
            S_IDLE: begin
                if (req) begin
                    a_q <= a;
                    b_q <= b;
                    // x + 0 passes x through untouched
                    if (a.exp == '0 && b.exp == '0) begin
                        res_q <= '0;
                    end else if (a.exp == '0) begin
                        res_q <= b;
                    end else begin
                        res_q <= a;
                    end
                end
            end
            S_ALIGN: begin
                sign_q <= base.sign;
                exp_q <= base.exp;
                sub_q <= base.sign ^ other.sign;
                big_q <= {1'b1, base.mant};
                small_q <= other_sig;
            end
            S_SUM: begin
                // base is never smaller, so the difference stays positive
                if (sub_q) begin
                    sum_q <= SUM_W'(big_q) - SUM_W'(small_q);
                end else begin
                    sum_q <= SUM_W'(big_q) + SUM_W'(small_q);
                end
            end
            S_NORM: begin
                if (sum_q[SIG_W]) begin
                    // carry out, drop the lowest bit
                    res_q.sign <= sign_q;
                    res_q.exp <= exp_q + EXP_W'(1);
                    res_q.mant <= sum_q[SIG_W-1:1];
                end else if (sum_q == '0) begin
                    // exact cancellation
                    res_q <= '0;
                end else begin
                    res_q.sign <= sign_q;
                    res_q.exp <= exp_q - EXP_W'(norm_shift);
                    res_q.mant <= norm_sig[float_pkg::MANT_WIDTH-1:0];
                end
            end
            S_PACK: out <= res_q;
            default: begin
            end
        endcase
    end

    // controller must wait for the ack before the next req
    req_only_in_idle: assert property (@(posedge clk) disable iff (rst)
        req |-> state == S_IDLE);

    ack_one_cycle: assert property (@(posedge clk) disable iff (rst)
        ack |=> !ack);

endmodule

`default_nettype wire

// ==== hw/float_unit_ctrl.sv ====
// Float unit controller
// takes one request through a valid/ready port, starts the selected
// arithmetic unit with a req pulse, waits for its ack and keeps the
// result until the consumer takes it
`timescale 1ns/1ns
`default_nettype none

module float_unit_ctrl (
    input  logic               clk,
    input  logic               rst,
    input  logic               in_valid,
    input  float_pkg::fp_req_t in_req,
    output logic               in_ready,
    output logic               res_valid,
    output float_pkg::float_t  res,
    input  logic               res_ready,
    output logic               mul_req,
    output logic               add_req,
    output float_pkg::float_t  op_a,
    output float_pkg::float_t  op_b,
    input  logic               mul_ack,
    input  logic               add_ack,
    input  float_pkg::float_t  mul_out,
    input  float_pkg::float_t  add_out
);

    // idle -> busy (unit working) -> hold (result waiting) -> idle
    typedef enum logic [1:0] {
        S_IDLE,
        S_BUSY,
        S_HOLD
    } state_e;

    state_e                state;
    float_pkg::fp_opcode_e op_q;
    logic                  accept;
    logic                  done;
    float_pkg::float_t     unit_out;

    // nothing in flight and result register empty
    assign in_ready = (state == S_IDLE);
    assign res_valid = (state == S_HOLD);
    assign accept = in_valid && in_ready;

    // only the unit that was started can answer
    assign done = (op_q == float_pkg::OP_MUL) ? mul_ack : add_ack;
    assign unit_out = (op_q == float_pkg::OP_MUL) ? mul_out : add_out;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state <= S_IDLE;
            op_q <= float_pkg::OP_MUL;
            mul_req <= 1'b0;
            add_req <= 1'b0;
        end else begin
            // req is a single-cycle pulse
            mul_req <= 1'b0;
            add_req <= 1'b0;
            case (state)
                S_IDLE: begin
                    if (accept) begin
                        op_q <= in_req.op;
                        mul_req <= (in_req.op == float_pkg::OP_MUL);
                        add_req <= (in_req.op == float_pkg::OP_ADD);
                        state <= S_BUSY;
                    end
                end
                S_BUSY: begin
                    if (done) begin
                        state <= S_HOLD;
                    end
                end
                S_HOLD: begin
                    if (res_ready) begin
                        state <= S_IDLE;
                    end
                end
                default: state <= S_IDLE;
            endcase
        end
    end

    // operands go out with the req pulse, result captured on the ack
    always_ff @(posedge clk) begin
        if (accept) begin
            op_a <= in_req.a;
            op_b <= in_req.b;
        end
        if (state == S_BUSY && done) begin
            res <= unit_out;
        end
    end

    // back-pressure keeps the result in place
    res_held: assert property (@(posedge clk) disable iff (rst)
        res_valid && !res_ready |=> res_valid && $stable(res));

    // a unit only answers a request that this controller is waiting on
    ack_only_busy: assert property (@(posedge clk) disable iff (rst)
        (mul_ack || add_ack) |-> state == S_BUSY);

endmodule

`default_nettype wire

// ==== hw/float_unit.sv ====
// Float arithmetic unit, top level
// controller plus one multiplier and one adder, a single operation
// in flight, valid/ready on both the request and the result side
`timescale 1ns/1ns
`default_nettype none

module float_unit (
    input  logic               clk,
    input  logic               rst,
    input  logic               in_valid,
    input  float_pkg::fp_req_t in_req,
    output logic               in_ready,
    output logic               res_valid,
    output float_pkg::float_t  res,
    input  logic               res_ready
);

    logic              mul_req;
    logic              add_req;
    logic              mul_ack;
    logic              add_ack;
    // both units see the same operand registers
    float_pkg::float_t op_a;
    float_pkg::float_t op_b;
    float_pkg::float_t mul_out;
    float_pkg::float_t add_out;

    float_unit_ctrl u_ctrl (
        .clk       (clk),
        .rst       (rst),
        .in_valid  (in_valid),
        .in_req    (in_req),
        .in_ready  (in_ready),
        .res_valid (res_valid),
        .res       (res),
        .res_ready (res_ready),
        .mul_req   (mul_req),
        .add_req   (add_req),
        .op_a      (op_a),
        .op_b      (op_b),
        .mul_ack   (mul_ack),
        .add_ack   (add_ack),
        .mul_out   (mul_out),
        .add_out   (add_out)
    );

    float_mul u_mul (
        .clk (clk),
        .rst (rst),
        .req (mul_req),
        .a   (op_a),
        .b   (op_b),
        .ack (mul_ack),
        .out (mul_out)
    );

    float_add u_add (
        .clk (clk),
        .rst (rst),
        .req (add_req),
        .a   (op_a),
        .b   (op_b),
        .ack (add_ack),
        .out (add_out)
    );

endmodule

`default_nettype wire

// ==== verification/float_model.svh ====
// Float unit reference model
// expected product and sum under the unit's number rules
// zero exponent field counts as zero, results truncate, no special values
`ifndef FLOAT_MODEL_SVH
`define FLOAT_MODEL_SVH
`default_nettype none

function automatic float_pkg::float_t model_mul(input float_pkg::float_t a,
                                                input float_pkg::float_t b);
    float_pkg::float_t r;
    logic [47:0]       prod;
    int                exp_val;
    r = '0;
    // flushed operand gives +0
    if (a.exp == 8'd0 || b.exp == 8'd0) begin
        return r;
    end
    prod = {24'd0, 1'b1, a.mant} * {24'd0, 1'b1, b.mant};
    exp_val = int'(a.exp) + int'(b.exp) - 127;
    // product of two [1,2) values lies in [1,4)
    if (prod[47]) begin
        prod = prod >> 24;
        exp_val = exp_val + 1;
    end else begin
        prod = prod >> 23;
    end
    r.sign = a.sign ^ b.sign;
    r.exp = 8'(exp_val);
    r.mant = prod[22:0];
    return r;
endfunction

function automatic float_pkg::float_t model_add(input float_pkg::float_t a,
                                                input float_pkg::float_t b);
    float_pkg::float_t base;
    float_pkg::float_t other;
    float_pkg::float_t r;
    int                diff;
    int                shifted;
    int                sum;
    int                exp_val;
    r = '0;
    if (a.exp == 8'd0 && b.exp == 8'd0) begin
        return r;
    end
    if (a.exp == 8'd0) begin
        return b;
    end
    if (b.exp == 8'd0) begin
        return a;
    end
    // larger magnitude sets sign and exponent, a wins a tie
    if ({a.exp, a.mant} >= {b.exp, b.mant}) begin
        base = a;
        other = b;
    end else begin
        base = b;
        other = a;
    end
    diff = int'(base.exp) - int'(other.exp);
    shifted = (diff >= 25) ? 0 : (int'({1'b1, other.mant}) >> diff);
    if (base.sign == other.sign) begin
        sum = int'({1'b1, base.mant}) + shifted;
    end else begin
        sum = int'({1'b1, base.mant}) - shifted;
    end
    if (sum == 0) begin
        return r;
    end
    exp_val = int'(base.exp);
    if (sum >= (1 << 24)) begin
        sum = sum >> 1;
        exp_val = exp_val + 1;
    end
    // bring the leading one up to bit 23
    while (sum < (1 << 23)) begin
        sum = sum << 1;
        exp_val = exp_val - 1;
    end
    r.sign = base.sign;
    r.exp = 8'(exp_val);
    r.mant = 23'(sum);
    return r;
endfunction

`default_nettype wire
`endif

// ==== verification/float_unit_tb.sv ====
// Float unit testbench
// directed multiply and add cases, LFSR-driven random operations
// checked against the reference model, and result back-pressure
`timescale 1ns/1ns
`include "float_model.svh"
`default_nettype none

module float_unit_tb;

    // 5 mul + 6 add directed, random ops, 2 under back-pressure
    localparam int RANDOM_OPS = 200;
    localparam int NUM_OPS = 5 + 6 + RANDOM_OPS + 2;
    localparam int MAX_CYCLES = 40 * NUM_OPS;
    localparam int HOLD_CYCLES = 20;

    logic               clk;
    logic               rst;
    logic               in_valid;
    float_pkg::fp_req_t in_req;
    logic               in_ready;
    logic               res_valid;
    float_pkg::float_t  res;
    logic               res_ready;
    logic [31:0]        lfsr;
    int                 cycle_count = 0;

    float_unit dut0 (
        .clk       (clk),
        .rst       (rst),
        .in_valid  (in_valid),
        .in_req    (in_req),
        .in_ready  (in_ready),
        .res_valid (res_valid),
        .res       (res),
        .res_ready (res_ready)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    task automatic fail_run(input string msg);
        $display("%s", msg);
        $display("Regression failed");
        $fatal(1, "simulation stopped at the first error");
    endtask

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= MAX_CYCLES) begin
            fail_run($sformatf("Timeout: tests still running after %0d cycles", MAX_CYCLES));
        end
    end

    // x^32 + x^22 + x^2 + x + 1, new bit enters at the bottom
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    function automatic logic [31:0] take_bits(input int n);
        logic [31:0] bits;
        bits = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr_next(lfsr);
            bits = {bits[30:0], lfsr[0]};
        end
        return bits;
    endfunction

    // exponent kept in 64..190, clear of overflow and underflow
    function automatic float_pkg::float_t random_float();
        float_pkg::float_t f;
        logic [31:0]       bits;
        bits = take_bits(1);
        f.sign = bits[0];
        bits = take_bits(7);
        f.exp = 8'(64 + (bits % 127));
        bits = take_bits(23);
        f.mant = bits[22:0];
        return f;
    endfunction

    task automatic check_flag(input string name, input logic got, input logic expected);
        assert (got === expected) else begin
            fail_run($sformatf("Error at %0t: %s is %b, expected %b", $time, name, got, expected));
        end
    endtask

    task automatic check_res(input float_pkg::float_t expected);
        assert (res === expected) else begin
            fail_run($sformatf("Error at %0t: res is %h, expected %h", $time, res, expected));
        end
    endtask

    // request already on the port, all sampling on falling edges
    task automatic accept_and_wait();
        while (!in_ready) @(negedge clk);
        // accepted on the rising edge in between
        @(negedge clk);
        in_valid = 1'b0;
        while (!res_valid) @(negedge clk);
    endtask

    task automatic run_op(input float_pkg::fp_req_t req);
        in_req = req;
        in_valid = 1'b1;
        accept_and_wait();
    endtask

    task automatic take_res();
        res_ready = 1'b1;
        @(negedge clk);
        res_ready = 1'b0;
    endtask

    task automatic check_op(input float_pkg::fp_opcode_e op, input float_pkg::float_t a,
                            input float_pkg::float_t b, input float_pkg::float_t expected);
        float_pkg::fp_req_t req;
        req.op = op;
        req.a = a;
        req.b = b;
        run_op(req);
        check_res(expected);
        take_res();
    endtask

    task automatic test_reset_state();
        check_flag("in_ready", in_ready, 1'b1);
        check_flag("res_valid", res_valid, 1'b0);
    endtask

    task automatic test_mul();
        // 2*3, 1.5*1.5 and a negative operand
        check_op(float_pkg::OP_MUL, 32'h4000_0000, 32'h4040_0000, 32'h40c0_0000);
        check_op(float_pkg::OP_MUL, 32'h3fc0_0000, 32'h3fc0_0000, 32'h4010_0000);
        check_op(float_pkg::OP_MUL, 32'hc000_0000, 32'h4040_0000, 32'hc0c0_0000);
        // zero and a negative denormal both flush to +0
        check_op(float_pkg::OP_MUL, 32'h0000_0000, 32'h4040_0000, 32'h0000_0000);
        check_op(float_pkg::OP_MUL, 32'h8000_0001, 32'hc000_0000, 32'h0000_0000);
    endtask

    task automatic test_add();
        // 1+1 carries, 3+(-1) renormalises, 3+(-3) cancels
        check_op(float_pkg::OP_ADD, 32'h3f80_0000, 32'h3f80_0000, 32'h4000_0000);
        check_op(float_pkg::OP_ADD, 32'h4040_0000, 32'hbf80_0000, 32'h4000_0000);
        check_op(float_pkg::OP_ADD, 32'h4040_0000, 32'hc040_0000, 32'h0000_0000);
        // zero-exponent operand passes the other one through
        check_op(float_pkg::OP_ADD, 32'h0000_0005, 32'h4040_0000, 32'h4040_0000);
        check_op(float_pkg::OP_ADD, 32'hc000_0000, 32'h0000_0000, 32'hc000_0000);
        check_op(float_pkg::OP_ADD, 32'h8000_0000, 32'h0000_0003, 32'h0000_0000);
    endtask

    task automatic test_random();
        float_pkg::float_t     a;
        float_pkg::float_t     b;
        float_pkg::fp_opcode_e op;
        logic [31:0]           bits;
        for (int n = 0; n < RANDOM_OPS; n++) begin
            bits = take_bits(1);
            op = bits[0] ? float_pkg::OP_ADD : float_pkg::OP_MUL;
            a = random_float();
            b = random_float();
            if (op == float_pkg::OP_MUL) begin
                check_op(op, a, b, model_mul(a, b));
            end else begin
                check_op(op, a, b, model_add(a, b));
            end
        end
    endtask

    task automatic test_backpressure();
        float_pkg::fp_req_t first;
        float_pkg::fp_req_t second;
        float_pkg::float_t  held;
        // 1.5 * -2.0 = -3.0, then 2.0 + 0.5 = 2.5
        first.op = float_pkg::OP_MUL;
        first.a = 32'h3fc0_0000;
        first.b = 32'hc000_0000;
        second.op = float_pkg::OP_ADD;
        second.a = 32'h4000_0000;
        second.b = 32'h3f00_0000;
        held = 32'hc040_0000;
        run_op(first);
        check_res(held);
        // second request waits on the port while the result sits
        in_req = second;
        in_valid = 1'b1;
        repeat (HOLD_CYCLES) begin
            @(negedge clk);
            check_flag("res_valid", res_valid, 1'b1);
            check_flag("in_ready", in_ready, 1'b0);
            check_res(held);
        end
        take_res();
        accept_and_wait();
        check_res(32'h4020_0000);
        take_res();
    endtask

    initial begin
        lfsr = 32'h54c3_8d9d;
        rst = 1'b1;
        in_valid = 1'b0;
        in_req = '0;
        res_ready = 1'b0;
        repeat (8) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        test_reset_state();
        test_mul();
        test_add();
        test_random();
        test_backpressure();
        $display("Regression passed");
        $finish;
    end

endmodule

`default_nettype wire

// ==== tb.f ====
+incdir+verification
hw/float_pkg.sv
hw/float_mul.sv
hw/float_add.sv
hw/float_unit_ctrl.sv
hw/float_unit.sv
verification/float_unit_tb.sv

// ==== run.sh ====
#!/bin/sh
# build the float unit testbench with Verilator and run it
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f tb.f --top-module float_unit_tb -o float_unit_sim

sim_out=$(./obj_dir/float_unit_sim 2>&1 || true)
echo "$sim_out"

if echo "$sim_out" | grep -qx "Regression passed"; then
    exit 0
fi
exit 1
